// ==== vram_regs.f ====
+incdir+.
xm_reg_pkg.sv
vram_bus_pkg.sv
bus_sync.sv
xm_regfile.sv
vram_access.sv
tick_timer.sv
vram_regs.sv
tb_clk_gen.sv
vram_regs_chk.sv
vram_regs_tb.sv

// ==== Bender.yml ====
package:
  name: vram_regs

sources:
  - include_dirs:
      - .
    files:
      - xm_reg_pkg.sv
      - vram_bus_pkg.sv
      - bus_sync.sv
      - xm_regfile.sv
      - vram_access.sv
      - tick_timer.sv
      - vram_regs.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - vram_regs_chk.sv
      - vram_regs_tb.sv

// ==== vram_regs_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "vram_regs_defs.svh"

module vram_regs_tb;

localparam logic [31:0] SEED          = 32'hbf35_6b00;
localparam int          CLK_PERIOD_NS = 10;
localparam int          N_WORDS       = 8;      // words per VRAM test
localparam int          TIMER_GAP     = 350;    // idle cycles between timer reads
localparam int          ACCESS_EST    = 150;    // bus accesses over all tests, ~11 cycles each
localparam int          WATCHDOG_NS   = 10 * CLK_PERIOD_NS * (ACCESS_EST * 11 + TIMER_GAP);

logic                   clk;
logic                   reset;
logic                   bus_cs_n;
logic                   bus_rd_nwr;
logic [3:0]             bus_reg_num;
logic                   bus_bytesel;
logic [7:0]             bus_wdata;
logic [7:0]             bus_rdata;
logic                   vram_ack;
logic [15:0]            vram_rdata;
logic                   vram_sel;
logic                   vram_wr;
logic [15:0]            vram_addr;
logic [15:0]            vram_wdata;
logic [3:0]             vram_wrmask;
logic [`XM_INTR_W-1:0]  intr_status;
logic [`XM_INTR_W-1:0]  intr_mask;
logic [`XM_INTR_W-1:0]  intr_clear;

logic [15:0]            vram_mem [0:65535];     // VRAM model storage
logic [31:0]            tb_rng;
logic [31:0]            model_rng;              // separate stream for ack delays
int                     errors = 0;
int                     test_start_errors = 0;
int                     tests_run = 0;
int                     tests_failed = 0;
logic [`XM_INTR_W-1:0]  clear_seen;
int                     clear_pulses = 0;

tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(5)) u_clk_gen (
    .clk        (clk),
    .reset_o    (reset)
);

vram_regs dut (
    .clk            (clk),
    .reset_i        (reset),
    .bus_cs_n_i     (bus_cs_n),
    .bus_rd_nwr_i   (bus_rd_nwr),
    .bus_reg_num_i  (bus_reg_num),
    .bus_bytesel_i  (bus_bytesel),
    .bus_data_i     (bus_wdata),
    .bus_data_o     (bus_rdata),
    .vram_ack_i     (vram_ack),
    .vram_data_i    (vram_rdata),
    .vram_sel_o     (vram_sel),
    .vram_wr_o      (vram_wr),
    .vram_addr_o    (vram_addr),
    .vram_data_o    (vram_wdata),
    .vram_wrmask_o  (vram_wrmask),
    .intr_status_i  (intr_status),
    .intr_mask_o    (intr_mask),
    .intr_clear_o   (intr_clear)
);

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [15:0] rand16();
    tb_rng = lcg_step(tb_rng);
    return tb_rng[31:16];                       // upper bits mix best
endfunction

function automatic logic [15:0] fill_word(input logic [15:0] a);
    return {a[7:0], a[15:8]} ^ 16'h5aa5;        // every address bit counts
endfunction

// nibble i taken from new word when mask bit i is set
function automatic logic [15:0] merge_nibbles(input logic [15:0] old_w,
                                              input logic [15:0] new_w,
                                              input logic [3:0] mask);
    logic [15:0] r;
    for (int i = 0; i < 4; i++) begin
        r[i*4 +: 4] = mask[i] ? new_w[i*4 +: 4] : old_w[i*4 +: 4];
    end
    return r;
endfunction

// VRAM model, ack after 1 to 4 cycles
initial begin
    int delay;
    vram_ack   = 1'b0;
    vram_rdata = '0;
    model_rng  = SEED ^ 32'h0000_ffff;
    for (int a = 0; a < 65536; a++) begin
        vram_mem[a] = fill_word(a[15:0]);
    end
    forever begin
        @(posedge clk);
        #1;
        if (!reset && vram_sel) begin
            model_rng = lcg_step(model_rng);
            delay = 1 + model_rng[17:16];
            for (int i = 1; i < delay; i++) begin
                @(posedge clk);
                #1;
            end
            if (vram_wr) begin
                vram_mem[vram_addr] = merge_nibbles(vram_mem[vram_addr], vram_wdata, vram_wrmask);
            end else begin
                vram_rdata = vram_mem[vram_addr];
            end
            vram_ack = 1'b1;                    // sampled on the next edge
            @(posedge clk);
            #1;
            vram_ack = 1'b0;
        end
    end
end

// counts clear pulses
always @(posedge clk) begin
    if (!reset && |intr_clear) begin
        clear_seen = intr_clear;
        clear_pulses++;
    end
end

task automatic report_mismatch(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
    $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
    errors++;
endtask

task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_start_errors) begin
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
endtask

// one bus cycle, 5 clocks select low then 5 high
task automatic bus_access(input logic rd, input logic [3:0] num, input logic odd,
                          input logic [7:0] wdata, output logic [7:0] rdata);
    @(posedge clk);
    #1;
    bus_cs_n    = 1'b0;
    bus_rd_nwr  = rd;
    bus_reg_num = num;
    bus_bytesel = odd;
    bus_wdata   = wdata;
    repeat (4) @(posedge clk);
    #1;
    rdata = bus_rdata;                          // last low cycle
    @(posedge clk);
    #1;
    bus_cs_n = 1'b1;
    repeat (4) @(posedge clk);
endtask

task automatic bus_write(input logic [3:0] num, input logic odd, input logic [7:0] data);
    logic [7:0] unused;
    bus_access(1'b0, num, odd, data, unused);
endtask

task automatic bus_read(input logic [3:0] num, input logic odd, output logic [7:0] data);
    bus_access(1'b1, num, odd, 8'h00, data);
endtask

task automatic write_word(input logic [3:0] num, input logic [15:0] w);
    bus_write(num, 1'b0, w[15:8]);              // even byte first
    bus_write(num, 1'b1, w[7:0]);
endtask

task automatic read_word(input logic [3:0] num, output logic [15:0] w);
    bus_read(num, 1'b0, w[15:8]);
    bus_read(num, 1'b1, w[7:0]);
endtask

task automatic wait_idle();
    logic [7:0] hi;
    bus_read(xm_reg_pkg::SYS_CTRL, 1'b0, hi);
    while (hi[7]) begin                         // busy is bit 15
        bus_read(xm_reg_pkg::SYS_CTRL, 1'b0, hi);
    end
endtask

task automatic check_reg(input logic [3:0] num, input logic [15:0] exp);
    logic [15:0] w;
    read_word(num, w);
    if (w !== exp) report_mismatch($sformatf("reg %0d", num), w, exp);
endtask

task automatic test_reset_state();
    check_reg(xm_reg_pkg::SYS_CTRL, 16'h000f);
    check_reg(xm_reg_pkg::RD_ADDR, 16'h0000);
    check_reg(xm_reg_pkg::WR_ADDR, 16'h0000);
    check_reg(xm_reg_pkg::RD_INCR, 16'h0000);
    check_reg(xm_reg_pkg::WR_INCR, 16'h0000);
    check_reg(xm_reg_pkg::INT_CTRL, 16'h0000);
    if (vram_sel !== 1'b0) report_mismatch("vram_sel_o", {15'b0, vram_sel}, 16'h0000);
    finish_test("reset_state");
endtask

task automatic test_readback();
    logic [15:0] v;
    logic [3:0]  num;
    for (int i = 0; i < 3; i++) begin
        num = (i == 0) ? xm_reg_pkg::RD_INCR :
              (i == 1) ? xm_reg_pkg::WR_INCR : xm_reg_pkg::WR_ADDR;
        v = rand16();
        write_word(num, v);
        check_reg(num, v);
    end
    for (int n = 9; n < 16; n++) begin
        check_reg(n[3:0], 16'h0000);            // unused numbers
    end
    finish_test("readback");
endtask

task automatic test_vram_write();
    logic [15:0] start;
    logic [15:0] incr;
    logic [3:0]  mask;
    logic [15:0] addr;
    logic [15:0] data;
    logic [15:0] exp_words [N_WORDS];
    start = rand16();
    incr  = rand16() & 16'h00ff | 16'h0001;     // odd step, no address repeats
    mask  = rand16() & 4'hf | 4'h1;
    write_word(xm_reg_pkg::WR_ADDR, start);
    write_word(xm_reg_pkg::WR_INCR, incr);
    write_word(xm_reg_pkg::SYS_CTRL, {12'h000, mask});
    for (int k = 0; k < N_WORDS; k++) begin
        addr = start + k[15:0] * incr;
        data = rand16();
        exp_words[k] = merge_nibbles(vram_mem[addr], data, mask);
        wait_idle();
        write_word(k[0] ? xm_reg_pkg::DATA_2 : xm_reg_pkg::DATA, data);
    end
    wait_idle();
    for (int k = 0; k < N_WORDS; k++) begin
        addr = start + k[15:0] * incr;
        if (vram_mem[addr] !== exp_words[k]) begin
            report_mismatch($sformatf("vram[%h]", addr), vram_mem[addr], exp_words[k]);
        end
    end
    check_reg(xm_reg_pkg::WR_ADDR, start + N_WORDS[15:0] * incr);
    write_word(xm_reg_pkg::SYS_CTRL, 16'h000f); // back to full mask
    finish_test("vram_write");
endtask

task automatic test_vram_preread();
    logic [15:0] start;
    logic [15:0] incr;
    logic [15:0] addr;
    logic [15:0] w;
    start = rand16();
    incr  = rand16() & 16'h00ff | 16'h0001;
    for (int k = 0; k <= N_WORDS; k++) begin
        vram_mem[start + k[15:0] * incr] = rand16();
    end
    write_word(xm_reg_pkg::RD_INCR, incr);
    write_word(xm_reg_pkg::RD_ADDR, start);     // odd byte starts first fetch
    for (int k = 0; k < N_WORDS; k++) begin
        addr = start + k[15:0] * incr;
        wait_idle();
        read_word(k[0] ? xm_reg_pkg::DATA_2 : xm_reg_pkg::DATA, w);
        if (w !== vram_mem[addr]) report_mismatch($sformatf("DATA at %h", addr), w, vram_mem[addr]);
    end
    wait_idle();
    // one fetch ahead of the words read
    check_reg(xm_reg_pkg::RD_ADDR, start + (N_WORDS[15:0] + 16'd1) * incr);
    finish_test("vram_preread");
endtask

task automatic test_timer();
    logic [7:0] hi;
    logic [7:0] lo_a;
    logic [7:0] lo_a2;
    logic [7:0] lo_b;
    logic [7:0] diff;
    time        t_a;
    time        t_b;
    int         expected;
    t_a = $time;
    bus_read(xm_reg_pkg::TIMER, 1'b0, hi);      // latches low byte
    bus_read(xm_reg_pkg::TIMER, 1'b1, lo_a);
    bus_read(xm_reg_pkg::TIMER, 1'b1, lo_a2);
    if (lo_a2 !== lo_a) report_mismatch("latched timer low byte", {8'h00, lo_a2}, {8'h00, lo_a});
    repeat (TIMER_GAP) @(posedge clk);
    t_b = $time;
    bus_read(xm_reg_pkg::TIMER, 1'b0, hi);
    bus_read(xm_reg_pkg::TIMER, 1'b1, lo_b);
    // latch edges sit the same distance from t_a and t_b
    expected = int'((t_b - t_a) / CLK_PERIOD_NS) / `XM_TICK_CLKS;
    diff = lo_b - lo_a;
    if (int'(diff) > expected + 1 || int'(diff) + 1 < expected) begin
        report_mismatch("timer ticks", {8'h00, diff}, expected[15:0]);
    end
    finish_test("timer");
endtask

task automatic test_interrupts();
    logic [`XM_INTR_W-1:0] mask;
    logic [`XM_INTR_W-1:0] status;
    logic [`XM_INTR_W-1:0] clr;
    mask   = rand16();
    status = rand16();
    clr    = rand16() | 7'h01;                  // nonzero so a pulse shows
    bus_write(xm_reg_pkg::INT_CTRL, 1'b0, {1'b0, mask});
    @(posedge clk);
    #1;
    intr_status = status;
    check_reg(xm_reg_pkg::INT_CTRL, {1'b0, mask, 1'b0, status});
    if (intr_mask !== mask) report_mismatch("intr_mask_o", {9'b0, intr_mask}, {9'b0, mask});
    clear_pulses = 0;
    bus_write(xm_reg_pkg::INT_CTRL, 1'b1, {1'b0, clr});
    if (clear_pulses != 1) begin
        $display("intr_clear_o pulsed %0d times for one clear write", clear_pulses);
        errors++;
    end else if (clear_seen !== clr) begin
        report_mismatch("intr_clear_o", {9'b0, clear_seen}, {9'b0, clr});
    end
    @(posedge clk);
    #1;
    intr_status = '0;
    finish_test("interrupts");
endtask

initial begin
    bus_cs_n    = 1'b1;                         // bus idle
    bus_rd_nwr  = 1'b1;
    bus_reg_num = '0;
    bus_bytesel = 1'b0;
    bus_wdata   = '0;
    intr_status = '0;
    tb_rng      = SEED;
    wait (reset === 1'b1);
    wait (reset === 1'b0);
    @(posedge clk);
    test_reset_state();
    test_readback();
    test_vram_write();
    test_vram_preread();
    test_timer();
    test_interrupts();
    errors = errors + dut.u_access.u_chk.assert_failures;
    $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, dut.u_access.u_chk.assert_failures);
    if (errors == 0) begin
        $display("Simulation finished: PASS");
    end else begin
        $display("Simulation finished: FAIL");
    end
    $finish;
end

// watchdog
initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
end

endmodule

`default_nettype wire

// ==== vram_regs_chk.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "vram_regs_defs.svh"

module vram_regs_chk (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire vram_bus_pkg::acc_state_e   state_i,
    input  wire logic                       req_i,
    input  wire logic                       sel_i,
    input  wire logic                       ack_i,
    input  wire logic [`XM_ADDR_W-1:0]      addr_i,
    input  wire logic                       busy_i
);

int assert_failures = 0;                        // failed assertions so far

// select may only drop after an acknowledge
sel_held: assert property (@(posedge clk) disable iff (reset_i)
    sel_i && !ack_i |=> sel_i)
    else begin
        assert_failures++;
        $error("vram select dropped before acknowledge");
    end

// address frozen for the whole access
addr_stable: assert property (@(posedge clk) disable iff (reset_i)
    sel_i && !ack_i |=> $stable(addr_i))
    else begin
        assert_failures++;
        $error("vram address changed while select was high");
    end

// request taken in IDLE raises busy on the next edge
busy_rise: assert property (@(posedge clk) disable iff (reset_i)
    state_i == vram_bus_pkg::IDLE && req_i |=> busy_i)
    else begin
        assert_failures++;
        $error("busy flag did not rise after a request in IDLE");
    end

// busy clears on the edge after acknowledge
busy_fall: assert property (@(posedge clk) disable iff (reset_i)
    busy_i && ack_i |=> !busy_i)
    else begin
        assert_failures++;
        $error("busy flag still high after acknowledge");
    end

endmodule

bind vram_access vram_regs_chk u_chk (
    .clk        (clk),
    .reset_i    (reset_i),
    .state_i    (state),
    .req_i      (mem_req_i.rd || mem_req_i.wr),
    .sel_i      (vram_sel_o),
    .ack_i      (vram_ack_i),
    .addr_i     (vram_addr_o),
    .busy_i     (mem_busy_o)
);

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset_o
);

initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
end

initial begin
    reset_o = 1'b1;                             // held from time zero
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_o = 1'b0;                             // released just after an edge
end

endmodule

`default_nettype wire

// ==== vram_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "vram_regs_defs.svh"

module vram_regs (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    // cpu bus
    input  wire logic                       bus_cs_n_i,
    input  wire logic                       bus_rd_nwr_i,
    input  wire logic [`XM_REGNUM_W-1:0]    bus_reg_num_i,
    input  wire logic                       bus_bytesel_i,
    input  wire logic [7:0]                 bus_data_i,
    output      logic [7:0]                 bus_data_o,
    // VRAM port
    input  wire logic                       vram_ack_i,
    input  wire logic [`XM_DATA_W-1:0]      vram_data_i,
    output      logic                       vram_sel_o,
    output      logic                       vram_wr_o,
    output      logic [`XM_ADDR_W-1:0]      vram_addr_o,
    output      logic [`XM_DATA_W-1:0]      vram_data_o,
    output      logic [3:0]                 vram_wrmask_o,
    // interrupts
    input  wire logic [`XM_INTR_W-1:0]      intr_status_i,
    output      logic [`XM_INTR_W-1:0]      intr_mask_o,
    output      logic [`XM_INTR_W-1:0]      intr_clear_o
);

xm_reg_pkg::bus_op_t        bus_op;             // synced bus access
vram_bus_pkg::mem_req_t     mem_req;
vram_bus_pkg::mem_rsp_t     mem_rsp;
logic                       mem_busy;
xm_reg_pkg::word_t          timer;

bus_sync u_bus_sync (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n_i),
    .bus_rd_nwr_i   (bus_rd_nwr_i),
    .bus_bytesel_i  (bus_bytesel_i),
    .bus_reg_num_i  (bus_reg_num_i),
    .bus_data_i     (bus_data_i),
    .bus_op_o       (bus_op)
);

xm_regfile u_regfile (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_op_i       (bus_op),
    .bus_data_o     (bus_data_o),
    .mem_req_o      (mem_req),
    .mem_rsp_i      (mem_rsp),
    .mem_busy_i     (mem_busy),
    .timer_i        (timer),
    .intr_status_i  (intr_status_i),
    .intr_mask_o    (intr_mask_o),
    .intr_clear_o   (intr_clear_o)
);

vram_access u_access (
    .clk            (clk),
    .reset_i        (reset_i),
    .mem_req_i      (mem_req),
    .mem_rsp_o      (mem_rsp),
    .mem_busy_o     (mem_busy),
    .vram_ack_i     (vram_ack_i),
    .vram_data_i    (vram_data_i),
    .vram_sel_o     (vram_sel_o),
    .vram_wr_o      (vram_wr_o),
    .vram_addr_o    (vram_addr_o),
    .vram_data_o    (vram_data_o),
    .vram_wrmask_o  (vram_wrmask_o)
);

tick_timer u_timer (
    .clk            (clk),
    .reset_i        (reset_i),
    .timer_o        (timer)
);

endmodule

`default_nettype wire

// ==== tick_timer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "vram_regs_defs.svh"

module tick_timer #(
    parameter int TICK_CLKS = `XM_TICK_CLKS,    // clock count per period
    parameter int TICK_HZ   = 1                 // ticks per period
) (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    output      xm_reg_pkg::word_t          timer_o
);

// fractional accumulator
// sign bit clear means a tick is due
localparam int FRAC_W = $clog2(TICK_CLKS) + 1;

logic [FRAC_W-1:0]          frac;
logic                       tick;
xm_reg_pkg::word_t          count;

assign tick = !frac[FRAC_W-1];

always_ff @(posedge clk) begin
    if (reset_i) begin
        frac  <= '0;
        count <= '0;
    end else begin
        if (tick) begin
            frac  <= frac + FRAC_W'(TICK_HZ - TICK_CLKS);  // wraps negative
            count <= count + 1'b1;
        end else begin
            frac  <= frac + FRAC_W'(TICK_HZ);
        end
    end
end

assign timer_o = count;

endmodule

`default_nettype wire

// ==== vram_access.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "vram_regs_defs.svh"

module vram_access (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire vram_bus_pkg::mem_req_t     mem_req_i,
    output      vram_bus_pkg::mem_rsp_t     mem_rsp_o,
    output      logic                       mem_busy_o,
    input  wire logic                       vram_ack_i,     // access finished
    input  wire logic [`XM_DATA_W-1:0]      vram_data_i,
    output      logic                       vram_sel_o,
    output      logic                       vram_wr_o,
    output      logic [`XM_ADDR_W-1:0]      vram_addr_o,
    output      logic [`XM_DATA_W-1:0]      vram_data_o,
    output      logic [3:0]                 vram_wrmask_o
);

vram_bus_pkg::acc_state_e   state;
vram_bus_pkg::addr_t        addr_q;
vram_bus_pkg::data_t        wdata_q;
logic [3:0]                 mask_q;
vram_bus_pkg::data_t        rdata_q;
logic                       rd_done;
logic                       wr_done;
logic                       take_req;

// pulses outside IDLE are lost
assign take_req = (state == vram_bus_pkg::IDLE) && (mem_req_i.rd || mem_req_i.wr);

always_ff @(posedge clk) begin
    if (reset_i) begin
        state   <= vram_bus_pkg::IDLE;
        rd_done <= 1'b0;
        wr_done <= 1'b0;
    end else begin
        rd_done <= 1'b0;
        wr_done <= 1'b0;
        case (state)
            vram_bus_pkg::IDLE: begin
                if (mem_req_i.wr) begin
                    state <= vram_bus_pkg::WAIT_WR;
                end else if (mem_req_i.rd) begin
                    state <= vram_bus_pkg::WAIT_RD;
                end
            end
            vram_bus_pkg::WAIT_RD: begin
                if (vram_ack_i) begin
                    state   <= vram_bus_pkg::IDLE;
                    rd_done <= 1'b1;
                end
            end
            vram_bus_pkg::WAIT_WR: begin
                if (vram_ack_i) begin
                    state   <= vram_bus_pkg::IDLE;
                    wr_done <= 1'b1;
                end
            end
            default: state <= vram_bus_pkg::IDLE;
        endcase
    end
end

// address and data held for the whole access
always_ff @(posedge clk) begin
    if (take_req) begin
        addr_q  <= mem_req_i.addr;
        wdata_q <= mem_req_i.data;
        mask_q  <= mem_req_i.mask;
    end
    if (state == vram_bus_pkg::WAIT_RD && vram_ack_i) begin
        rdata_q <= vram_data_i;
    end
end

assign mem_busy_o    = (state != vram_bus_pkg::IDLE);
assign vram_sel_o    = (state != vram_bus_pkg::IDLE);   // drops the edge after ack
assign vram_wr_o     = (state == vram_bus_pkg::WAIT_WR);
assign vram_addr_o   = addr_q;
assign vram_data_o   = wdata_q;
assign vram_wrmask_o = mask_q;

always_comb begin
    mem_rsp_o.rd_done = rd_done;
    mem_rsp_o.wr_done = wr_done;
    mem_rsp_o.rd_data = rdata_q;
end

endmodule

`default_nettype wire

// ==== xm_regfile.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "vram_regs_defs.svh"

module xm_regfile (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire xm_reg_pkg::bus_op_t        bus_op_i,
    output      xm_reg_pkg::byte_t          bus_data_o,
    output      vram_bus_pkg::mem_req_t     mem_req_o,
    input  wire vram_bus_pkg::mem_rsp_t     mem_rsp_i,
    input  wire logic                       mem_busy_i,     // sequencer not idle
    input  wire xm_reg_pkg::word_t          timer_i,
    input  wire logic [`XM_INTR_W-1:0]      intr_status_i,
    output      logic [`XM_INTR_W-1:0]      intr_mask_o,
    output      logic [`XM_INTR_W-1:0]      intr_clear_o    // one-cycle clear pulse
);

xm_reg_pkg::word_t          reg_rd_incr;
vram_bus_pkg::addr_t        reg_rd_addr;
xm_reg_pkg::word_t          reg_wr_incr;
vram_bus_pkg::addr_t        reg_wr_addr;
xm_reg_pkg::word_t          reg_data;           // last pre-read word
xm_reg_pkg::byte_t          reg_data_even;      // pending high byte of DATA
logic [3:0]                 reg_wrmask;
xm_reg_pkg::byte_t          timer_latch;        // low byte frozen on high read
xm_reg_pkg::word_t          rd_word;

xm_reg_pkg::xm_reg_e        reg_sel;
logic                       wr_even;
logic                       wr_odd;
logic                       is_data;
logic                       issue_wr;
logic                       issue_rd;
vram_bus_pkg::addr_t        pre_addr;

logic                       req_rd;
logic                       req_wr;
vram_bus_pkg::addr_t        req_addr;
vram_bus_pkg::data_t        req_data;

// operation decode
always_comb begin
    reg_sel  = xm_reg_pkg::xm_reg_e'(bus_op_i.reg_num);
    wr_even  = bus_op_i.wr && !bus_op_i.bytesel;
    wr_odd   = bus_op_i.wr && bus_op_i.bytesel;
    is_data  = (reg_sel == xm_reg_pkg::DATA) || (reg_sel == xm_reg_pkg::DATA_2);
    issue_wr = wr_odd && is_data;
    issue_rd = (wr_odd && reg_sel == xm_reg_pkg::RD_ADDR)
            || (bus_op_i.rd && bus_op_i.bytesel && is_data);
    // new RD_ADDR is not registered yet on its own low byte write
    pre_addr = bus_op_i.wr ? {reg_rd_addr[15:8], bus_op_i.data} : reg_rd_addr;
end

// read mux
always_comb begin
    case (reg_sel)
        xm_reg_pkg::SYS_CTRL:   rd_word = {mem_busy_i, 11'b0, reg_wrmask};
        xm_reg_pkg::INT_CTRL:   rd_word = {1'b0, intr_mask_o, 1'b0, intr_status_i};
        xm_reg_pkg::TIMER:      rd_word = {timer_i[15:8], timer_latch};
        xm_reg_pkg::RD_INCR:    rd_word = reg_rd_incr;
        xm_reg_pkg::RD_ADDR:    rd_word = reg_rd_addr;
        xm_reg_pkg::WR_INCR:    rd_word = reg_wr_incr;
        xm_reg_pkg::WR_ADDR:    rd_word = reg_wr_addr;
        xm_reg_pkg::DATA,
        xm_reg_pkg::DATA_2:     rd_word = reg_data;
        default:                rd_word = '0;   // unused numbers
    endcase
end

assign bus_data_o = bus_op_i.bytesel ? rd_word[7:0] : rd_word[15:8];

always_ff @(posedge clk) begin
    if (reset_i) begin
        reg_rd_incr   <= '0;
        reg_rd_addr   <= '0;
        reg_wr_incr   <= '0;
        reg_wr_addr   <= '0;
        reg_data      <= '0;
        reg_data_even <= '0;
        reg_wrmask    <= 4'b1111;               // all nibbles written
        timer_latch   <= '0;
        intr_mask_o   <= '0;
        intr_clear_o  <= '0;
    end else begin
        intr_clear_o <= '0;

        // completions step the matching address
        if (mem_rsp_i.rd_done) begin
            reg_data    <= mem_rsp_i.rd_data;
            reg_rd_addr <= reg_rd_addr + reg_rd_incr;
        end
        if (mem_rsp_i.wr_done) begin
            reg_wr_addr <= reg_wr_addr + reg_wr_incr;
        end

        // even byte goes to the high half
        if (wr_even) begin
            case (reg_sel)
                xm_reg_pkg::INT_CTRL:   intr_mask_o       <= bus_op_i.data[`XM_INTR_W-1:0];
                xm_reg_pkg::RD_INCR:    reg_rd_incr[15:8] <= bus_op_i.data;
                xm_reg_pkg::RD_ADDR:    reg_rd_addr[15:8] <= bus_op_i.data;
                xm_reg_pkg::WR_INCR:    reg_wr_incr[15:8] <= bus_op_i.data;
                xm_reg_pkg::WR_ADDR:    reg_wr_addr[15:8] <= bus_op_i.data;
                xm_reg_pkg::DATA,
                xm_reg_pkg::DATA_2:     reg_data_even     <= bus_op_i.data;
                default: begin
                end
            endcase
        end

        // odd byte completes the word
        if (wr_odd) begin
            case (reg_sel)
                xm_reg_pkg::SYS_CTRL:   reg_wrmask       <= bus_op_i.data[3:0];
                xm_reg_pkg::INT_CTRL:   intr_clear_o     <= bus_op_i.data[`XM_INTR_W-1:0];
                xm_reg_pkg::RD_INCR:    reg_rd_incr[7:0] <= bus_op_i.data;
                xm_reg_pkg::RD_ADDR:    reg_rd_addr[7:0] <= bus_op_i.data;
                xm_reg_pkg::WR_INCR:    reg_wr_incr[7:0] <= bus_op_i.data;
                xm_reg_pkg::WR_ADDR:    reg_wr_addr[7:0] <= bus_op_i.data;
                default: begin
                end
            endcase
        end

        if (bus_op_i.rd && !bus_op_i.bytesel && reg_sel == xm_reg_pkg::TIMER) begin
            timer_latch <= timer_i[7:0];        // odd read returns this byte
        end
    end
end

// request strobes
always_ff @(posedge clk) begin
    if (reset_i) begin
        req_rd <= 1'b0;
        req_wr <= 1'b0;
    end else begin
        req_rd <= issue_rd;
        req_wr <= issue_wr;
    end
end

// request payload
always_ff @(posedge clk) begin
    if (issue_wr) begin
        req_addr <= reg_wr_addr;
        req_data <= {reg_data_even, bus_op_i.data};
    end else if (issue_rd) begin
        req_addr <= pre_addr;
    end
end

always_comb begin
    mem_req_o.rd   = req_rd;
    mem_req_o.wr   = req_wr;
    mem_req_o.addr = req_addr;
    mem_req_o.data = req_data;
    mem_req_o.mask = reg_wrmask;
end

endmodule

`default_nettype wire

// ==== bus_sync.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "vram_regs_defs.svh"

module bus_sync (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       bus_cs_n_i,     // async chip select
    input  wire logic                       bus_rd_nwr_i,   // high for read
    input  wire logic                       bus_bytesel_i,  // high for odd byte
    input  wire logic [`XM_REGNUM_W-1:0]    bus_reg_num_i,
    input  wire xm_reg_pkg::byte_t          bus_data_i,
    output      xm_reg_pkg::bus_op_t        bus_op_o
);

logic                       cs_meta;            // first sync stage
logic                       cs_sync;            // second sync stage
logic                       cs_last;            // previous synced value
logic                       cs_fall;
logic                       wr_stb;
logic                       rd_stb;
logic [`XM_REGNUM_W-1:0]    reg_num_q;
logic                       bytesel_q;
xm_reg_pkg::byte_t          data_q;

assign cs_fall = cs_last && !cs_sync;           // select just went active

always_ff @(posedge clk) begin
    if (reset_i) begin
        cs_meta <= 1'b1;                        // bus idle is high
        cs_sync <= 1'b1;
        cs_last <= 1'b1;
        wr_stb  <= 1'b0;
        rd_stb  <= 1'b0;
    end else begin
        cs_meta <= bus_cs_n_i;
        cs_sync <= cs_meta;
        cs_last <= cs_sync;
        wr_stb  <= cs_fall && !bus_rd_nwr_i;
        rd_stb  <= cs_fall && bus_rd_nwr_i;
    end
end

// bus fields are stable by the time the synced edge shows up
always_ff @(posedge clk) begin
    if (cs_fall) begin
        reg_num_q <= bus_reg_num_i;
        bytesel_q <= bus_bytesel_i;
        data_q    <= bus_data_i;
    end
end

always_comb begin
    bus_op_o.wr      = wr_stb;
    bus_op_o.rd      = rd_stb;
    bus_op_o.reg_num = reg_num_q;               // keeps read mux steady
    bus_op_o.bytesel = bytesel_q;
    bus_op_o.data    = data_q;
end

endmodule

`default_nettype wire

// ==== vram_bus_pkg.sv ====
`default_nettype none

`include "vram_regs_defs.svh"

package vram_bus_pkg;

typedef logic [`XM_ADDR_W-1:0]  addr_t;         // VRAM word address
typedef logic [`XM_DATA_W-1:0]  data_t;         // VRAM word

// single cycle request pulse from the register file
typedef struct packed {
    logic                       rd;             // pre-read request
    logic                       wr;             // write request
    addr_t                      addr;
    data_t                      data;           // write data
    logic [3:0]                 mask;           // nibble write enables
} mem_req_t;

// completion back to the register file
typedef struct packed {
    logic                       rd_done;        // pulse with rd_data valid
    logic                       wr_done;        // pulse after write ack
    data_t                      rd_data;
} mem_rsp_t;

// access sequencer states
typedef enum logic [1:0] {
    IDLE,                                       // ready for a request
    WAIT_RD,                                    // select held for read ack
    WAIT_WR                                     // select held for write ack
} acc_state_e;

endpackage

`default_nettype wire

// ==== xm_reg_pkg.sv ====
`default_nettype none

`include "vram_regs_defs.svh"

package xm_reg_pkg;

typedef logic [7:0]             byte_t;         // cpu bus byte
typedef logic [`XM_DATA_W-1:0]  word_t;         // register word

// register numbers as seen on the cpu bus
typedef enum logic [`XM_REGNUM_W-1:0] {
    SYS_CTRL    = 0,                            // busy flag and write mask
    INT_CTRL    = 1,                            // interrupt mask and status
    TIMER       = 2,                            // free running tick count
    RD_INCR     = 3,
    RD_ADDR     = 4,                            // odd byte write starts pre-read
    WR_INCR     = 5,
    WR_ADDR     = 6,
    DATA        = 7,                            // VRAM data port
    DATA_2      = 8                             // second alias of DATA
} xm_reg_e;

// one synchronized bus access
typedef struct packed {
    logic                       wr;             // one-cycle write strobe
    logic                       rd;             // one-cycle read strobe
    logic [`XM_REGNUM_W-1:0]    reg_num;        // held until next access
    logic                       bytesel;        // set for odd byte
    byte_t                      data;           // write data byte
} bus_op_t;

endpackage

`default_nettype wire

// ==== vram_regs_defs.svh ====
`ifndef VRAM_REGS_DEFS_SVH
`define VRAM_REGS_DEFS_SVH

// bus and memory widths
`define XM_DATA_W       16      // register and VRAM word width
`define XM_ADDR_W       16      // VRAM word address width
`define XM_REGNUM_W     4       // register number width

// interrupt sources
`define XM_INTR_W       7

// clocks per timer tick
// short for simulation builds
// board builds override TICK_CLKS on tick_timer
`define XM_TICK_CLKS    10

`endif
